// File: hw/rns_alu.sv
//================================================
// One residue channel of the execute stage
//================================================

`timescale 1ns/1ps
`include "rns_macros.svh"

module rns_alu import rns_pkg::*; #(
    parameter int MODULUS = `RNS_MOD_A    // 256 or 129
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     s1_load,
    input  logic     s2_load,
    input  alu_op_e  op,
    input  residue_t a,
    input  residue_t b,
    output residue_t y
);

    residue_t opa;          // Prepared operands
    residue_t opb;

    residue_t s1_a;         // Stage 1 registers
    residue_t s1_b;
    alu_op_e  s1_op;

    product_t raw;          // Unreduced sum or product
    residue_t fit;          // Reduced into the channel range

    residue_t s2_y;         // Stage 2 result register

    rns_operand_prep #(
        .MODULUS (MODULUS)
    ) prep_i (
        .a   (a),
        .b   (b),
        .op  (op),
        .opa (opa),
        .opb (opb)
    );

    // Operation is the only control state held in the channel
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_op <= OP_ADD;
        end else if (s1_load) begin
            s1_op <= op;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_load) begin
            s1_a <= opa;
            s1_b <= opb;
        end
    end

    // Subtraction arrives here as an addition of the inverse
    always_comb begin
        if (s1_op == OP_MUL) begin
            raw = product_t'(s1_a) * product_t'(s1_b);
        end else begin
            raw = product_t'(s1_a) + product_t'(s1_b);
        end
    end

    rns_mod_reduce #(
        .MODULUS (MODULUS)
    ) reduce_i (
        .value (raw),
        .res   (fit)
    );

    always_ff @(posedge clk) begin
        if (s2_load) begin
            s2_y <= fit;
        end
    end

    assign y = s2_y;

    // Stage 2 only ever loads from a stage 1 that pipe control has filled
    a_s2_known: assert property (
        @(posedge clk) disable iff (reset)
        s2_load |-> !$isunknown(fit)
    ) else $error("alu mod %0d: stage 2 loaded an unknown result", MODULUS);

endmodule

// File: hw/rns_ex_stage.sv
//================================================
// Residue execute stage top
//================================================

`timescale 1ns/1ps
`include "rns_macros.svh"

module rns_ex_stage import rns_pkg::*; (
    input  logic     clk,
    input  logic     reset,

    // Operand side
    input  logic     in_valid,
    output logic     in_ready,
    input  alu_op_e  op,
    input  residue_t a_r256,
    input  residue_t a_r129,
    input  residue_t b_r256,
    input  residue_t b_r129,

    // Result side
    output logic     out_valid,
    input  logic     out_ready,
    output residue_t y_r256,
    output residue_t y_r129
);

    logic s1_load;      // Shared by both channels so they stay in lockstep
    logic s2_load;

    rns_pipe_ctrl ctrl_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .s1_load   (s1_load),
        .s2_load   (s2_load)
    );

    rns_alu #(
        .MODULUS (`RNS_MOD_A)
    ) alu_r256_i (
        .clk     (clk),
        .reset   (reset),
        .s1_load (s1_load),
        .s2_load (s2_load),
        .op      (op),
        .a       (a_r256),
        .b       (b_r256),
        .y       (y_r256)
    );

    rns_alu #(
        .MODULUS (`RNS_MOD_B)
    ) alu_r129_i (
        .clk     (clk),
        .reset   (reset),
        .s1_load (s1_load),
        .s2_load (s2_load),
        .op      (op),
        .a       (a_r129),
        .b       (b_r129),
        .y       (y_r129)
    );

endmodule

// File: hw/rns_macros.svh
//================================================
// Residue number system widths and moduli
//================================================

`ifndef RNS_MACROS_SVH
`define RNS_MACROS_SVH

// One residue of either channel
`define RNS_RES_W   8

// Raw sum or product before reduction
`define RNS_PROD_W  16

// Channel A modulus, reduction is a plain truncation
`define RNS_MOD_A   256

// Channel B modulus, 2^7 + 1
`define RNS_MOD_B   129

`endif

// File: hw/rns_mod_reduce.sv
//================================================
// Modular reduction of a raw result
//================================================

`timescale 1ns/1ps
`include "rns_macros.svh"

module rns_mod_reduce import rns_pkg::*; #(
    parameter int MODULUS = `RNS_MOD_A    // 256 or 129
) (
    input  product_t value,
    output residue_t res
);

    generate
        if (MODULUS == `RNS_MOD_A) begin : g_trunc
            assign res = value[`RNS_RES_W-1:0];   // Drop everything above 2^8

        end else begin : g_fold_129
            localparam int LOW_W  = 7;                       // 2^7 is -1 mod 129
            localparam int HIGH_W = `RNS_PROD_W - LOW_W;
            localparam int DIFF_W = HIGH_W + 2;              // Room for the sign

            logic        [LOW_W-1:0]  low_digit;
            logic        [HIGH_W-1:0] high_part;
            logic signed [DIFF_W-1:0] low_ext;
            logic signed [DIFF_W-1:0] high_ext;
            logic signed [DIFF_W-1:0] diff;

            assign low_digit = value[LOW_W-1:0];
            assign high_part = value[`RNS_PROD_W-1:LOW_W];

            assign low_ext  = {{(DIFF_W-LOW_W){1'b0}}, low_digit};
            assign high_ext = {2'b00, high_part};

            // value = high * 128 + low, which is low - high mod 129
            assign diff = low_ext - high_ext;

            // For value up to 128*128 the difference is at least -128
            assign res = diff[DIFF_W-1] ? residue_t'(diff + MODULUS)
                                        : residue_t'(diff);
        end
    endgenerate

    // Holds only while callers keep value within the folding range
    a_res_range: assert final (int'(res) < MODULUS)
        else $error("mod reduce: value %0d gave %0d, not below %0d",
                    value, res, MODULUS);

endmodule

// File: hw/rns_operand_prep.sv
//================================================
// Residue operand preparation
//================================================

`timescale 1ns/1ps
`include "rns_macros.svh"

module rns_operand_prep import rns_pkg::*; #(
    parameter int MODULUS = `RNS_MOD_A    // 256 or 129
) (
    input  residue_t a,
    input  residue_t b,
    input  alu_op_e  op,
    output residue_t opa,
    output residue_t opb
);

    residue_t a_fit;    // Operands brought into range
    residue_t b_fit;

    generate
        if (MODULUS == `RNS_MOD_B) begin : g_fold
            // An 8 bit raw value can exceed 128 by at most one modulus
            assign a_fit = (a >= residue_t'(MODULUS)) ? a - residue_t'(MODULUS) : a;
            assign b_fit = (b >= residue_t'(MODULUS)) ? b - residue_t'(MODULUS) : b;
        end else begin : g_pass
            assign a_fit = a;   // Every 8 bit value is a valid mod 256 residue
            assign b_fit = b;
        end
    endgenerate

    always_comb begin
        opa = a_fit;
        opb = b_fit;
        if (op == OP_SUB && b_fit != '0) begin
            opb = residue_t'(MODULUS - int'(b_fit));  // Additive inverse of b
        end
    end

    // Subtraction then reuses the adder in the channel
    a_opa_range: assert final (int'(opa) < MODULUS)
        else $error("operand prep: opa %0d not below modulus %0d", opa, MODULUS);

    a_opb_range: assert final (int'(opb) < MODULUS)
        else $error("operand prep: opb %0d not below modulus %0d", opb, MODULUS);

endmodule

// File: hw/rns_pipe_ctrl.sv
//================================================
// Two stage pipeline handshake control
//================================================

`timescale 1ns/1ps

module rns_pipe_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    output logic in_ready,
    output logic out_valid,
    input  logic out_ready,
    output logic s1_load,
    output logic s2_load
);

    logic s1_valid;     // Stage 1 holds prepared operands
    logic s2_valid;     // Stage 2 holds a finished result

    // Stage 2 takes the stage 1 item when empty or when it drains this cycle
    assign s2_load = s1_valid && (!s2_valid || out_ready);

    // Stage 1 accepts when empty or when its item moves on
    assign in_ready = !s1_valid || s2_load;
    assign s1_load  = in_valid && in_ready;

    assign out_valid = s2_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s1_load) begin
                s1_valid <= 1'b1;
            end else if (s2_load) begin
                s1_valid <= 1'b0;       // Moved on with nothing behind it
            end

            if (s2_load) begin
                s2_valid <= 1'b1;
            end else if (out_ready) begin
                s2_valid <= 1'b0;       // Result taken downstream
            end
        end
    end

    // A stalled result must stay offered until the sink takes it
    a_out_hold: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid
    ) else $error("pipe ctrl: out_valid dropped while out_ready low");

    // Source keeps in_valid low in reset, and nothing is pending when reset ends
    a_no_load_in_reset: assert property (
        @(posedge clk)
        reset |-> !s1_load ##1 !s2_load
    ) else $error("pipe ctrl: stage load during reset");

endmodule

// File: hw/rns_pkg.sv
//================================================
// Residue execute stage types
//================================================

`include "rns_macros.svh"

package rns_pkg;

    // One residue, wide enough for both moduli
    typedef logic [`RNS_RES_W-1:0] residue_t;

    // Unreduced result of the arithmetic step
    typedef logic [`RNS_PROD_W-1:0] product_t;

    // Decoded operation, shared by both channels
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,  // a + b
        OP_SUB = 2'd1,  // a + (-b)
        OP_MUL = 2'd2   // a * b
    } alu_op_e;

endpackage

// File: tb.f
+incdir+hw
+incdir+testbench
hw/rns_pkg.sv
hw/rns_operand_prep.sv
hw/rns_mod_reduce.sv
hw/rns_pipe_ctrl.sv
hw/rns_alu.sv
hw/rns_ex_stage.sv
testbench/tb_rns_ex_stage.sv

// File: testbench/tb_rns_checks.svh
//================================================
// Residue reference model and compare tasks
//================================================

// Expected residue from plain integer arithmetic
function automatic residue_t rns_ref(
    input alu_op_e  op_in,
    input residue_t a,
    input residue_t b,
    input int       modulus
);
    int x;
    int y;
    int r;
    x = int'(a) % modulus;      // Raw mod 129 inputs fold back into range
    y = int'(b) % modulus;
    case (op_in)
        OP_ADD:  r = x + y;
        OP_SUB:  r = x - y + modulus;   // Kept non-negative before the modulo
        OP_MUL:  r = x * y;
        default: r = 0;
    endcase
    return residue_t'(r % modulus);
endfunction

// One residue of one channel against its expected value
task automatic check_residue(
    input string    name,
    input residue_t expected,
    input residue_t actual
);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
    end
endtask

// One handshake or status bit against its expected level
task automatic check_handshake(
    input string name,
    input bit    expected,
    input logic  actual
);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("[FAIL] %s: expected %0b, actual %0b", name, expected, actual);
    end
endtask

// Marks the start of a test so its own errors can be counted
task automatic begin_test(input string name);
    test_name   = name;
    test_errors = error_count;
    exp_r256_q.delete();    // Leftovers of a test that timed out
    exp_r129_q.delete();
endtask

task automatic end_test();
    int n;
    n = error_count - test_errors;
    if (n == 0) begin
        tests_passed++;
        $display("Test %s: ok", test_name);
    end else begin
        tests_failed++;
        $display("Test %s: failed with %0d errors", test_name, n);
    end
endtask

// File: testbench/tb_rns_ex_stage.sv
//================================================
// Residue execute stage testbench
//================================================

`timescale 1ns/1ps
`include "rns_macros.svh"

module tb_rns_ex_stage import rns_pkg::*; ();

    localparam int WAIT_LIMIT = 1000;   // Cycles before a wait gives up

    logic     clk;
    logic     reset;
    logic     in_valid;
    logic     in_ready;
    alu_op_e  op;
    residue_t a_r256;
    residue_t a_r129;
    residue_t b_r256;
    residue_t b_r129;
    logic     out_valid;
    logic     out_ready;
    residue_t y_r256;
    residue_t y_r129;

    int       seed = 25;
    int       error_count = 0;
    int       check_count = 0;
    int       tests_passed = 0;
    int       tests_failed = 0;
    int       test_errors = 0;
    string    test_name = "reset";
    logic     random_ready;         // Random back-pressure on out_ready

    residue_t exp_r256_q[$];        // Expected results in order of acceptance
    residue_t exp_r129_q[$];

    `include "tb_rns_checks.svh"

    rns_ex_stage dut_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op),
        .a_r256    (a_r256),
        .a_r129    (a_r129),
        .b_r256    (b_r256),
        .b_r129    (b_r129),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .y_r256    (y_r256),
        .y_r129    (y_r129)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(negedge clk) begin
        if (random_ready) begin
            out_ready = $random(seed) & 1;
        end
    end

    // Scoreboard pushes on input transfers and compares on output transfers
    always @(posedge clk) begin
        if (!reset) begin
            if (out_valid && out_ready) begin
                if (exp_r256_q.size() == 0 || exp_r129_q.size() == 0) begin
                    error_count++;
                    $display("Test %s: result came out with none expected", test_name);
                end else begin
                    check_residue({test_name, " y_r256"}, exp_r256_q.pop_front(), y_r256);
                    check_residue({test_name, " y_r129"}, exp_r129_q.pop_front(), y_r129);
                end
            end
            if (in_valid && in_ready) begin
                exp_r256_q.push_back(rns_ref(op, a_r256, b_r256, `RNS_MOD_A));
                exp_r129_q.push_back(rns_ref(op, a_r129, b_r129, `RNS_MOD_B));
            end
        end
    end

    // Offers one operand set and returns on the edge that accepts it
    task automatic send(
        input alu_op_e  op_in,
        input residue_t a256,
        input residue_t a129,
        input residue_t b256,
        input residue_t b129
    );
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid = 1'b1;
        op       = op_in;
        a_r256   = a256;
        a_r129   = a129;
        b_r256   = b256;
        b_r129   = b129;
        @(posedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                error_count++;
                $display("Test %s: in_ready stayed low, input never accepted", test_name);
                break;
            end
            @(posedge clk);
        end
    endtask

    // Stops offering input and waits until every expected result came out
    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid  = 1'b0;
        out_ready = 1'b1;
        while (exp_r256_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                error_count++;
                $display("Test %s: out_valid never delivered the pending results",
                         test_name);
                break;
            end
        end
    endtask

    task automatic run_stream(input int count);
        alu_op_e  op_r;
        residue_t a256;
        residue_t a129;
        residue_t b256;
        residue_t b129;
        random_ready = 1'b1;
        for (int i = 0; i < count; i++) begin
            op_r = alu_op_e'($unsigned($random(seed)) % 3);
            a256 = residue_t'($random(seed));
            a129 = residue_t'($random(seed));   // Full 8 bit range that the DUT folds
            b256 = residue_t'($random(seed));
            b129 = residue_t'($random(seed));
            send(op_r, a256, a129, b256, b129);
        end
        random_ready = 1'b0;
        drain();
        check_handshake("stream queue empty", 1'b1,
                        exp_r256_q.size() == 0 && exp_r129_q.size() == 0);
    endtask

    initial begin
        reset        = 1'b1;
        in_valid     = 1'b0;
        op           = OP_ADD;
        a_r256       = '0;
        a_r129       = '0;
        b_r256       = '0;
        b_r129       = '0;
        out_ready    = 1'b1;
        random_ready = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        begin_test("reset");
        @(posedge clk);
        check_handshake("reset out_valid", 1'b0, out_valid);
        check_handshake("reset in_ready", 1'b1, in_ready);
        end_test();

        begin_test("add_sub");
        send(OP_ADD, 200, 100, 100, 50);    // Both channels wrap
        send(OP_ADD, 255, 128, 1, 1);       // Exactly one modulus
        send(OP_SUB, 77, 77, 77, 77);       // a - a
        send(OP_SUB, 0, 0, 5, 5);           // 0 - b
        send(OP_SUB, 10, 20, 200, 100);     // b greater than a
        send(OP_SUB, 3, 128, 0, 0);
        drain();
        end_test();

        begin_test("mul_corners");
        send(OP_MUL, 255, 128, 255, 128);   // -1 times -1 in both channels
        send(OP_MUL, 0, 0, 123, 77);
        send(OP_MUL, 1, 1, 200, 100);
        send(OP_MUL, 97, 120, 1, 1);
        send(OP_MUL, 128, 127, 2, 127);
        drain();
        end_test();

        begin_test("mod129_fold");
        for (int i = 0; i < 3; i++) begin
            send(alu_op_e'(i), 40, 200, 9, 140);
            send(alu_op_e'(i), 129, 255, 7, 129);
            send(alu_op_e'(i), 250, 129, 3, 250);
        end
        drain();
        end_test();

        begin_test("stream");
        run_stream(200);
        end_test();

        // Accepted on one edge and offered on the second edge after it
        begin_test("latency");
        send(OP_ADD, 10, 20, 30, 40);
        @(negedge clk);
        in_valid = 1'b0;
        @(posedge clk);
        check_handshake("latency one cycle", 1'b0, out_valid);
        @(posedge clk);
        check_handshake("latency two cycles", 1'b1, out_valid);
        drain();
        end_test();

        $display("Tests passed: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests_passed, tests_failed, check_count, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
